/* common/vchess_pkg.sv */
package vchess_pkg;

   localparam int board_width = 256;        // 64 squares, 4 bits each
   localparam int eval_width = 16;
   localparam int trans_nodes_width = 16;
   localparam int depth_width = 8;
   localparam int flag_width = 2;

   localparam int max_positions_log2 = 5;
   localparam int max_positions = 1 << max_positions_log2;

   // Two batches worth of positions
   localparam int fifo_depth_log2 = 6;
   localparam int fifo_depth = 1 << fifo_depth_log2;
   localparam int fifo_width = board_width + 9;  // Board, side, castle, en passant

   localparam int table_index_width = 8;
   localparam int table_entries = 1 << table_index_width;
   localparam int key_width = 64 - table_index_width;

   // Key plus stored search fields, valid bit kept apart
   localparam int entry_width = key_width + eval_width + depth_width + flag_width
                                + trans_nodes_width + 1;

   // Hash, entry valid, capture, collision, depth, eval, flag, nodes
   localparam int result_width = 64 + 3 + depth_width + eval_width + flag_width
                                 + trans_nodes_width;

   localparam int hash_rotate = 7;          // Per-slice rotation step
   localparam logic [63:0] hash_side_const = 64'h9e37_79b9_7f4a_7c15;
   localparam logic [63:0] hash_castle_const = 64'hc2b2_ae3d_27d4_eb4f;
   localparam logic [63:0] hash_ep_const = 64'h1656_67b1_9e37_79f9;

endpackage

/* verilog/board_hash.sv */
`timescale 1ns/10ps

module board_hash
   (
   input  logic                                 clk,
   input  logic [vchess_pkg::board_width-1:0]   board,
   input  logic                                 white_to_move,
   input  logic [3:0]                           castle_mask,
   input  logic [3:0]                           en_passant_col,
   output logic [63:0]                          hash
   );

   import vchess_pkg::*;

   logic [63:0] hash_next;

   function automatic logic [63:0] rotl(input logic [63:0] value, input int unsigned amount);
      logic [127:0] doubled;
      doubled = {value, value} << (amount % 64);
      return doubled[127:64];
   endfunction

   always_comb
   begin
      hash_next = '0;
      // Slice k is rotated by k steps before folding
      for (int k = 0; k < board_width / 64; k++)
         hash_next = hash_next ^ rotl(board[64*k +: 64], k * hash_rotate);
      if (white_to_move)
         hash_next = hash_next ^ hash_side_const;
      hash_next = hash_next ^ 64'(hash_castle_const * castle_mask);  // Low 64 bits only
      hash_next = hash_next ^ rotl(hash_ep_const, en_passant_col);
   end

   always_ff @(posedge clk)
   begin
      hash <= hash_next;
   end

endmodule

/* verilog/trans.sv */
`timescale 1ns/10ps

module trans
   (
   input  logic                                       clk,
   input  logic                                       reset,
   input  logic                                       entry_lookup,
   input  logic                                       entry_store,
   input  logic [vchess_pkg::board_width-1:0]         board,
   input  logic                                       white_to_move,
   input  logic [3:0]                                 castle_mask,
   input  logic [3:0]                                 en_passant_col,
   input  logic [vchess_pkg::board_width-1:0]         store_board,
   input  logic                                       store_white_to_move,
   input  logic [3:0]                                 store_castle_mask,
   input  logic [3:0]                                 store_en_passant_col,
   input  logic signed [vchess_pkg::eval_width-1:0]   store_eval,
   input  logic [vchess_pkg::depth_width-1:0]         store_depth,
   input  logic [vchess_pkg::flag_width-1:0]          store_flag,
   input  logic [vchess_pkg::trans_nodes_width-1:0]   store_nodes,
   input  logic                                       store_capture,
   output logic                                       trans_idle,
   output logic                                       entry_valid,
   output logic signed [vchess_pkg::eval_width-1:0]   eval,
   output logic [vchess_pkg::depth_width-1:0]         depth,
   output logic [vchess_pkg::flag_width-1:0]          flag,
   output logic [vchess_pkg::trans_nodes_width-1:0]   nodes,
   output logic                                       capture,
   output logic                                       collision,
   output logic [63:0]                                hash
   );

   import vchess_pkg::*;

   logic [entry_width-1:0]          table_ram [table_entries];
   logic [table_entries-1:0]        valid_vec;
   logic [1:0]                      busy_cnt;
   logic                            is_store;

   logic [board_width-1:0]          pos_board;
   logic                            pos_white_to_move;
   logic [3:0]                      pos_castle_mask;
   logic [3:0]                      pos_en_passant_col;
   logic [entry_width-key_width-1:0] st_entry;   // Store fields, key joins at write

   logic [63:0]                     hash_w;
   logic [table_index_width-1:0]    index;
   logic [63:0]                     hash_q;
   logic [entry_width-1:0]          rd_entry;
   logic                            rd_valid;
   logic                            key_match;

   board_hash board_hash
      (.clk(clk), .board(pos_board), .white_to_move(pos_white_to_move),
       .castle_mask(pos_castle_mask), .en_passant_col(pos_en_passant_col),
       .hash(hash_w));

   assign index = hash_w[table_index_width-1:0];
   assign trans_idle = busy_cnt == 2'd0;
   assign key_match = rd_entry[entry_width-1 -: key_width] == hash_q[63 -: key_width];

   // Lookup runs 3 busy cycles, store 2; the last one does the work
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy_cnt <= 2'd0;
         is_store <= 1'b0;
         valid_vec <= '0;
         entry_valid <= 1'b0;
         collision <= 1'b0;
      end
      else if (entry_store || entry_lookup)
      begin
         busy_cnt <= entry_store ? 2'd2 : 2'd3;
         is_store <= entry_store;
      end
      else if (busy_cnt != 2'd0)
      begin
         busy_cnt <= busy_cnt - 1'b1;
         if (busy_cnt == 2'd1 && is_store)
            valid_vec[index] <= 1'b1;
         if (busy_cnt == 2'd1 && !is_store)
         begin
            entry_valid <= rd_valid && key_match;
            collision <= rd_valid && !key_match;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (entry_store)
      begin
         {pos_white_to_move, pos_castle_mask, pos_en_passant_col, pos_board} <=
            {store_white_to_move, store_castle_mask, store_en_passant_col, store_board};
         st_entry <= {store_eval, store_depth, store_flag, store_nodes, store_capture};
      end
      else if (entry_lookup)
         {pos_white_to_move, pos_castle_mask, pos_en_passant_col, pos_board} <=
            {white_to_move, castle_mask, en_passant_col, board};
      if (busy_cnt == 2'd1 && is_store)
         table_ram[index] <= {hash_w[63 -: key_width], st_entry};
      rd_entry <= table_ram[index];  // Read on the cycle the hash lands
      rd_valid <= valid_vec[index];
      hash_q <= hash_w;
      if (busy_cnt == 2'd1 && !is_store)
      begin
         {eval, depth, flag, nodes, capture} <= rd_entry[entry_width-key_width-1:0];
         hash <= hash_q;
      end
   end

endmodule

/* am_trans/board_fifo.sv */
`timescale 1ns/10ps

module board_fifo
   (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 init,
   input  logic                                 board_valid_in,
   input  logic [vchess_pkg::board_width-1:0]   board_in,
   input  logic                                 white_to_move_in,
   input  logic [3:0]                           castle_mask_in,
   input  logic [3:0]                           en_passant_col_in,
   input  logic                                 pop,
   output logic                                 not_empty,
   output logic [vchess_pkg::board_width-1:0]   board,
   output logic                                 white_to_move,
   output logic [3:0]                           castle_mask,
   output logic [3:0]                           en_passant_col
   );

   import vchess_pkg::*;

   logic [fifo_width-1:0]        fifo_ram [fifo_depth];
   logic [fifo_depth_log2-1:0]   wr_addr;
   logic [fifo_depth_log2-1:0]   rd_addr;
   logic [fifo_depth_log2:0]     count;
   logic                         board_valid_r;
   logic                         push;

   assign push = board_valid_in && !board_valid_r;  // One entry per rising edge
   assign not_empty = count != 0;

   always_ff @(posedge clk)
   begin
      if (reset || init)
      begin
         board_valid_r <= 1'b0;
         wr_addr <= '0;
         rd_addr <= '0;
         count <= '0;
      end
      else
      begin
         board_valid_r <= board_valid_in;
         if (push)
            wr_addr <= wr_addr + 1'b1;
         if (pop)
            rd_addr <= rd_addr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (!push && pop)
            count <= count - 1'b1;
      end
   end

   // Circular storage and registered head
   always_ff @(posedge clk)
   begin
      if (push)
         fifo_ram[wr_addr] <= {white_to_move_in, castle_mask_in, en_passant_col_in, board_in};
      if (pop)
         {white_to_move, castle_mask, en_passant_col, board} <= fifo_ram[rd_addr];
   end

endmodule

/* am_trans/lookup_sequencer.sv */
`timescale 1ns/10ps

module lookup_sequencer
   (
   input  logic clk,
   input  logic reset,
   input  logic not_empty,
   input  logic trans_idle,
   output logic pop,
   output logic entry_lookup,
   output logic result_wr
   );

   typedef enum logic [2:0]
   {
      s_idle,
      s_pop,
      s_lookup,
      s_wait,
      s_write
   } state_t;

   state_t state;
   state_t state_next;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= s_idle;
      else
         state <= state_next;
   end

   always_comb
   begin
      state_next = state;
      case (state)
         s_idle:
         begin
            if (trans_idle && not_empty)
               state_next = s_pop;
         end
         s_pop:
            state_next = s_lookup;       // FIFO head is loaded this cycle
         s_lookup:
            state_next = s_wait;
         s_wait:
         begin
            // Idle drops on the cycle after the strobe
            if (trans_idle)
               state_next = s_write;
         end
         s_write:
            state_next = s_idle;
         default:
            state_next = s_idle;
      endcase
   end

   // One-cycle pulses decoded from state
   assign pop = state == s_pop;
   assign entry_lookup = state == s_lookup;
   assign result_wr = state == s_write;

endmodule

/* am_trans/result_table.sv */
`timescale 1ns/10ps

module result_table
   (
   input  logic                                       clk,
   input  logic                                       init,
   input  logic                                       result_wr,
   input  logic                                       entry_valid,
   input  logic signed [vchess_pkg::eval_width-1:0]   eval,
   input  logic [vchess_pkg::depth_width-1:0]         depth,
   input  logic [vchess_pkg::flag_width-1:0]          flag,
   input  logic [vchess_pkg::trans_nodes_width-1:0]   nodes,
   input  logic                                       capture,
   input  logic                                       collision,
   input  logic [63:0]                                hash,
   input  logic [vchess_pkg::max_positions_log2-1:0]  trans_table_index,
   output logic                                       entry_valid_out,
   output logic signed [vchess_pkg::eval_width-1:0]   eval_out,
   output logic [vchess_pkg::depth_width-1:0]         depth_out,
   output logic [vchess_pkg::flag_width-1:0]          flag_out,
   output logic [vchess_pkg::trans_nodes_width-1:0]   nodes_out,
   output logic                                       capture_out,
   output logic                                       collision_out,
   output logic [63:0]                                hash_out,
   output logic [vchess_pkg::max_positions_log2:0]    result_count
   );

   import vchess_pkg::*;

   logic [result_width-1:0]      result_ram [max_positions];
   logic [max_positions_log2:0]  wr_addr;   // Extra bit so a full batch counts 32

   assign result_count = wr_addr;

   always_ff @(posedge clk)
   begin
      if (init)
         wr_addr <= '0;
      else if (result_wr)
         wr_addr <= wr_addr + 1'b1;
      if (result_wr)
         result_ram[wr_addr[max_positions_log2-1:0]] <=
            {hash, entry_valid, capture, collision, depth, eval, flag, nodes};
      {hash_out, entry_valid_out, capture_out, collision_out, depth_out, eval_out,
       flag_out, nodes_out} <= result_ram[trans_table_index];
   end

endmodule

/* am_trans/am_trans.sv */
`timescale 1ns/10ps

module am_trans
   (
   input  logic                                          clk,
   input  logic                                          reset,
   input  logic                                          init,
   input  logic [vchess_pkg::max_positions_log2-1:0]     trans_table_index,
   input  logic                                          board_valid_in,
   input  logic [vchess_pkg::board_width-1:0]            board_in,
   input  logic                                          white_to_move_in,
   input  logic [3:0]                                    castle_mask_in,
   input  logic [3:0]                                    en_passant_col_in,
   input  logic                                          entry_store,
   input  logic signed [vchess_pkg::eval_width-1:0]      store_eval,
   input  logic [vchess_pkg::depth_width-1:0]            store_depth,
   input  logic [vchess_pkg::flag_width-1:0]             store_flag,
   input  logic [vchess_pkg::trans_nodes_width-1:0]      store_nodes,
   input  logic                                          store_capture,
   output logic                                          entry_valid_out,
   output logic signed [vchess_pkg::eval_width-1:0]      eval_out,
   output logic [vchess_pkg::depth_width-1:0]            depth_out,
   output logic [vchess_pkg::flag_width-1:0]             flag_out,
   output logic [vchess_pkg::trans_nodes_width-1:0]      nodes_out,
   output logic                                          capture_out,
   output logic                                          collision_out,
   output logic [63:0]                                   hash_out,
   output logic [vchess_pkg::max_positions_log2:0]       result_count
   );

   import vchess_pkg::*;

   logic                            not_empty;
   logic                            pop;
   logic                            entry_lookup;
   logic                            result_wr;
   logic                            trans_idle;

   logic [board_width-1:0]          head_board;       // FIFO head position
   logic                            head_white_to_move;
   logic [3:0]                      head_castle_mask;
   logic [3:0]                      head_en_passant_col;

   logic                            tbl_entry_valid;
   logic signed [eval_width-1:0]    tbl_eval;
   logic [depth_width-1:0]          tbl_depth;
   logic [flag_width-1:0]           tbl_flag;
   logic [trans_nodes_width-1:0]    tbl_nodes;
   logic                            tbl_capture;
   logic                            tbl_collision;
   logic [63:0]                     tbl_hash;

   board_fifo board_fifo
      (.clk(clk), .reset(reset), .init(init), .board_valid_in(board_valid_in),
       .board_in(board_in), .white_to_move_in(white_to_move_in),
       .castle_mask_in(castle_mask_in), .en_passant_col_in(en_passant_col_in),
       .pop(pop), .not_empty(not_empty), .board(head_board),
       .white_to_move(head_white_to_move), .castle_mask(head_castle_mask),
       .en_passant_col(head_en_passant_col));

   lookup_sequencer lookup_sequencer
      (.clk(clk), .reset(reset), .not_empty(not_empty), .trans_idle(trans_idle),
       .pop(pop), .entry_lookup(entry_lookup), .result_wr(result_wr));

   trans trans
      (.clk(clk), .reset(reset), .entry_lookup(entry_lookup), .entry_store(entry_store),
       .board(head_board), .white_to_move(head_white_to_move),
       .castle_mask(head_castle_mask), .en_passant_col(head_en_passant_col),
       .store_board(board_in), .store_white_to_move(white_to_move_in),
       .store_castle_mask(castle_mask_in), .store_en_passant_col(en_passant_col_in),
       .store_eval(store_eval), .store_depth(store_depth), .store_flag(store_flag),
       .store_nodes(store_nodes), .store_capture(store_capture),
       .trans_idle(trans_idle), .entry_valid(tbl_entry_valid), .eval(tbl_eval),
       .depth(tbl_depth), .flag(tbl_flag), .nodes(tbl_nodes), .capture(tbl_capture),
       .collision(tbl_collision), .hash(tbl_hash));

   result_table result_table
      (.clk(clk), .init(init), .result_wr(result_wr),
       .entry_valid(tbl_entry_valid), .eval(tbl_eval), .depth(tbl_depth),
       .flag(tbl_flag), .nodes(tbl_nodes), .capture(tbl_capture),
       .collision(tbl_collision), .hash(tbl_hash),
       .trans_table_index(trans_table_index),
       .entry_valid_out(entry_valid_out), .eval_out(eval_out), .depth_out(depth_out),
       .flag_out(flag_out), .nodes_out(nodes_out), .capture_out(capture_out),
       .collision_out(collision_out), .hash_out(hash_out),
       .result_count(result_count));

endmodule

/* verif/am_trans_asserts.sv */
`timescale 1ns/10ps

module am_trans_asserts
   (
   input  logic clk,
   input  logic reset,
   input  logic pop,
   input  logic entry_lookup,
   input  logic result_wr,
   input  logic trans_idle,
   input  logic entry_store,
   input  logic entry_valid,
   input  logic collision
   );

   int fail_count = 0;   // Failed assertion count

   store_when_idle: assert property
      (@(posedge clk) disable iff (reset) entry_store |-> trans_idle)
      else
      begin
         fail_count++;
         $error("entry_store issued while trans_idle is low");
      end

   lookup_after_pop: assert property
      (@(posedge clk) disable iff (reset) pop |=> entry_lookup)
      else
      begin
         fail_count++;
         $error("entry_lookup missing one cycle after pop");
      end

   write_when_idle: assert property
      (@(posedge clk) disable iff (reset) result_wr |-> trans_idle)
      else
      begin
         fail_count++;
         $error("result_wr while the transposition unit is busy");
      end

   // Hit and collision are exclusive outcomes
   flags_exclusive: assert property
      (@(posedge clk) disable iff (reset) !(entry_valid && collision))
      else
      begin
         fail_count++;
         $error("entry_valid and collision set together");
      end

endmodule

/* verif/tb_am_trans.sv */
`timescale 1ns/10ps

module tb_am_trans;

   import vchess_pkg::*;

   localparam int num_batches = 7;
   localparam int cycle_limit = num_batches * (max_positions * 12 + max_positions + 200);
   localparam int fields_width = eval_width + depth_width + flag_width + trans_nodes_width + 1;

   logic                            clk;
   logic                            reset;
   logic                            init;
   logic [max_positions_log2-1:0]   trans_table_index;
   logic                            board_valid_in;
   logic [board_width-1:0]          board_in;
   logic                            white_to_move_in;
   logic [3:0]                      castle_mask_in;
   logic [3:0]                      en_passant_col_in;
   logic                            entry_store;
   logic signed [eval_width-1:0]    store_eval;
   logic [depth_width-1:0]          store_depth;
   logic [flag_width-1:0]           store_flag;
   logic [trans_nodes_width-1:0]    store_nodes;
   logic                            store_capture;
   logic                            entry_valid_out;
   logic signed [eval_width-1:0]    eval_out;
   logic [depth_width-1:0]          depth_out;
   logic [flag_width-1:0]           flag_out;
   logic [trans_nodes_width-1:0]    nodes_out;
   logic                            capture_out;
   logic                            collision_out;
   logic [63:0]                     hash_out;
   logic [max_positions_log2:0]     result_count;

   bit                              model_valid [table_entries];   // Reference table
   logic [key_width-1:0]            model_key [table_entries];
   logic [fields_width-1:0]         model_fields [table_entries];
   logic [board_width-1:0]          probe_board [max_positions];
   logic [8:0]                      probe_extra [max_positions];   // Side, castle, en passant
   logic [board_width-1:0]          saved_board [64];
   logic [8:0]                      saved_extra [64];
   int                              saved_count = 0;
   int                              value_errors = 0;
   int                              cycle_count = 0;
   int                              n;
   logic [63:0]                     hp;
   logic [63:0]                     hq;

   am_trans UUT
      (.clk(clk), .reset(reset), .init(init), .trans_table_index(trans_table_index),
       .board_valid_in(board_valid_in), .board_in(board_in),
       .white_to_move_in(white_to_move_in), .castle_mask_in(castle_mask_in),
       .en_passant_col_in(en_passant_col_in), .entry_store(entry_store),
       .store_eval(store_eval), .store_depth(store_depth), .store_flag(store_flag),
       .store_nodes(store_nodes), .store_capture(store_capture),
       .entry_valid_out(entry_valid_out), .eval_out(eval_out), .depth_out(depth_out),
       .flag_out(flag_out), .nodes_out(nodes_out), .capture_out(capture_out),
       .collision_out(collision_out), .hash_out(hash_out), .result_count(result_count));

   bind am_trans am_trans_asserts checks
      (.clk(clk), .reset(reset), .pop(pop), .entry_lookup(entry_lookup),
       .result_wr(result_wr), .trans_idle(trans_idle), .entry_store(entry_store),
       .entry_valid(tbl_entry_valid), .collision(tbl_collision));

   function automatic logic [63:0] rotate_left(input logic [63:0] value, input int amount);
      if (amount == 0)
         return value;
      return (value << amount) | (value >> (64 - amount));
   endfunction

   function automatic logic [63:0] position_hash(input logic [board_width-1:0] board,
                                                 input logic [8:0] extra);
      logic [63:0] h;
      logic [63:0] castle_term;
      h = '0;
      for (int k = 0; k < 4; k++)
         h = h ^ rotate_left(board[64*k +: 64], k * hash_rotate);
      if (extra[8])
         h = h ^ hash_side_const;                   // White to move
      castle_term = hash_castle_const * {60'd0, extra[7:4]};
      h = h ^ castle_term ^ rotate_left(hash_ep_const, int'(extra[3:0]));
      return h;
   endfunction

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] expected);
      if (got !== expected)
      begin
         $display("ERR %0t: %s got %h expected %h", $time, what, got, expected);
         value_errors++;
      end
   endtask

   task automatic random_probe(input int i);
      logic [31:0] r;
      for (int w = 0; w < board_width / 32; w++)
         probe_board[i][32*w +: 32] = $urandom;
      r = $urandom;
      probe_extra[i] = r[8:0];
   endtask

   // Random position whose table slot is still empty in the model
   task automatic fresh_probe(input int i);
      logic [63:0] h;
      do
      begin
         random_probe(i);
         h = position_hash(probe_board[i], probe_extra[i]);
      end
      while (model_valid[h[7:0]]);
   endtask

   task automatic store_probe(input int i);
      logic [63:0] h;
      logic [31:0] r;
      h = position_hash(probe_board[i], probe_extra[i]);
      @(negedge clk);
      board_in = probe_board[i];
      {white_to_move_in, castle_mask_in, en_passant_col_in} = probe_extra[i];
      r = $urandom;
      {store_eval, store_depth} = r[23:0];
      r = $urandom;
      {store_flag, store_nodes, store_capture} = r[18:0];
      entry_store = 1'b1;
      @(negedge clk);
      entry_store = 1'b0;
      while (!UUT.trans_idle)
         @(negedge clk);
      model_valid[h[7:0]] = 1'b1;
      model_key[h[7:0]] = h[63:8];
      model_fields[h[7:0]] = {store_eval, store_depth, store_flag, store_nodes, store_capture};
      saved_board[saved_count] = probe_board[i];
      saved_extra[saved_count] = probe_extra[i];
      saved_count++;
   endtask

   task automatic pulse_init();
      @(negedge clk);
      init = 1'b1;
      @(negedge clk);
      init = 1'b0;
   endtask

   task automatic check_results(input int count);
      logic [63:0] h;
      logic [7:0] idx;
      for (int i = 0; i < count; i++)
      begin
         trans_table_index = max_positions_log2'(i);
         @(negedge clk);                            // Read data one cycle after index
         h = position_hash(probe_board[i], probe_extra[i]);
         idx = h[7:0];
         check($sformatf("result %0d hash", i), hash_out, h);
         check($sformatf("result %0d entry valid", i), 64'(entry_valid_out),
               64'(model_valid[idx] && model_key[idx] == h[63:8]));
         check($sformatf("result %0d collision", i), 64'(collision_out),
               64'(model_valid[idx] && model_key[idx] != h[63:8]));
         if (model_valid[idx])
            check($sformatf("result %0d fields", i),
                  64'({eval_out, depth_out, flag_out, nodes_out, capture_out}),
                  64'(model_fields[idx]));
      end
   endtask

   task automatic run_batch(input int count);
      int gap;
      pulse_init();
      for (int i = 0; i < count; i++)
      begin
         @(negedge clk);
         board_in = probe_board[i];
         {white_to_move_in, castle_mask_in, en_passant_col_in} = probe_extra[i];
         board_valid_in = 1'b1;
         @(negedge clk);
         board_valid_in = 1'b0;
         gap = 1 + int'($urandom % 4);
         repeat (gap - 1)
            @(negedge clk);
      end
      while (result_count != count)
         @(negedge clk);
      repeat (12)                                   // Longer than one lookup
         @(negedge clk);
      check("result count", 64'(result_count), 64'(count));
      check_results(count);
   endtask

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout after %0d cycles, the DUT did not finish its batches", cycle_count);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial
   begin
      void'($urandom(98596));
      reset = 1'b1;
      init = 1'b1;                                  // Also clears the result count
      trans_table_index = '0;
      board_valid_in = 1'b0;
      board_in = '0;
      white_to_move_in = 1'b0;
      castle_mask_in = '0;
      en_passant_col_in = '0;
      entry_store = 1'b0;
      store_eval = '0;
      store_depth = '0;
      store_flag = '0;
      store_nodes = '0;
      store_capture = 1'b0;
      repeat (8)
         @(negedge clk);
      reset = 1'b0;
      init = 1'b0;

      for (int i = 0; i < 16; i++)                  // Stored hits
      begin
         fresh_probe(i);
         store_probe(i);
      end
      run_batch(16);

      n = 1 + int'($urandom % max_positions);       // Misses on empty slots
      for (int i = 0; i < n; i++)
         fresh_probe(i);
      run_batch(n);

      for (int c = 0; c < 4; c++)                   // Same index, different key
      begin
         fresh_probe(c);
         store_probe(c);
         hp = position_hash(probe_board[c], probe_extra[c]);
         do
         begin
            random_probe(4 + c);
            hq = position_hash(probe_board[4 + c], probe_extra[4 + c]);
         end
         while (hq[7:0] != hp[7:0] || hq == hp);
      end
      run_batch(8);

      for (int b = 0; b < 2; b++)                   // Mixed batches for order and count
      begin
         n = 1 + int'($urandom % max_positions);
         for (int i = 0; i < n; i++)
         begin
            if ($urandom % 2)
            begin
               hp[31:0] = $urandom % saved_count;
               probe_board[i] = saved_board[hp[31:0]];
               probe_extra[i] = saved_extra[hp[31:0]];
            end
            else
               random_probe(i);
         end
         run_batch(n);
      end

      for (int i = 0; i < saved_count; i++)        // Table survives init
      begin
         probe_board[i] = saved_board[i];
         probe_extra[i] = saved_extra[i];
      end
      run_batch(saved_count);

      pulse_init();                                 // Held level pushes once
      random_probe(0);
      @(negedge clk);
      board_in = probe_board[0];
      {white_to_move_in, castle_mask_in, en_passant_col_in} = probe_extra[0];
      board_valid_in = 1'b1;
      repeat (10)
         @(negedge clk);
      board_valid_in = 1'b0;
      while (result_count != 1)
         @(negedge clk);
      repeat (20)
         @(negedge clk);
      check("held level result count", 64'(result_count), 64'd1);
      check_results(1);

      $display("Summary: %0d value errors, %0d assertion failures",
               value_errors, UUT.checks.fail_count);
      if (value_errors == 0 && UUT.checks.fail_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* am_trans.f */
common/vchess_pkg.sv
verilog/board_hash.sv
verilog/trans.sv
am_trans/board_fifo.sv
am_trans/lookup_sequencer.sv
am_trans/result_table.sv
am_trans/am_trans.sv
verif/am_trans_asserts.sv
verif/tb_am_trans.sv

/* Makefile */
# Verilator build and run for the am_trans testbench

VERILATOR ?= verilator
TOP       ?= tb_am_trans
FILELIST  ?= am_trans.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
